// File: hw/branch_pkg.sv
package branch_pkg;

  // program counter width in instruction words.
  localparam int ADDR_WIDTH = 16;

  typedef enum logic [3:0] {
    JMP_OP_NOP = 4'd0,
    JMP_OP_J   = 4'd1,
    JMP_OP_JR  = 4'd2,
    JMP_OP_JEQ = 4'd3,
    JMP_OP_JNE = 4'd4,
    JMP_OP_JL  = 4'd5,
    JMP_OP_JLE = 4'd6,
    JMP_OP_JG  = 4'd7,
    JMP_OP_JGE = 4'd8,
    JMP_OP_JZ  = 4'd9,
    JMP_OP_JNZ = 4'd10
  } jump_op_e;

  typedef struct packed {
    logic zero;
    logic less;
    logic greater;
  } alu_flags_t;

  // one bit per pipeline register.
  typedef struct packed {
    logic pc;
    logic if_id;
    logic id_ex;
    logic ex_mem;
  } flush_mask_t;

  localparam flush_mask_t FLUSH_NONE   = 4'b0000;
  localparam flush_mask_t FLUSH_EX_MEM = 4'b0001;
  localparam flush_mask_t FLUSH_ALL    = 4'b1111;

  typedef struct packed {
    jump_op_e               jop;
    alu_flags_t             flags;
    logic [ADDR_WIDTH-1:0]  pc;
    logic [ADDR_WIDTH-1:0]  reg_address;
    logic [ADDR_WIDTH-1:0]  imm_address;
    logic                   predicted_taken;
  } ex_branch_t;

  typedef struct packed {
    flush_mask_t            flush;
    logic [ADDR_WIDTH-1:0]  jump_address;
  } redirect_t;

  typedef struct packed {
    logic                   resolved;
    logic                   mispredict;
    logic                   taken;
    logic [ADDR_WIDTH-1:0]  key;
    logic [ADDR_WIDTH-1:0]  target;
  } lut_update_t;

  typedef struct packed {
    logic                   taken;
    logic [ADDR_WIDTH-1:0]  target;
  } predict_t;

  // true for the ops that depend on the alu flags.
  function automatic logic is_cond_jump(jump_op_e jop);
    case (jop)
      JMP_OP_JEQ, JMP_OP_JNE, JMP_OP_JL, JMP_OP_JLE,
      JMP_OP_JG, JMP_OP_JGE, JMP_OP_JZ, JMP_OP_JNZ: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

endpackage

// File: hw/apb_pkg.sv
package apb_pkg;

  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic        pready;
    logic [31:0] prdata;
    logic        pslverr;
  } apb_rsp_t;

  // register map of the branch control block.
  localparam logic [7:0] REG_CTRL       = 8'h00;
  localparam logic [7:0] REG_RESOLVED   = 8'h04;
  localparam logic [7:0] REG_MISPREDICT = 8'h08;

  // ctrl fields, clear is write only.
  localparam int CTRL_ENABLE_BIT = 0;
  localparam int CTRL_CLEAR_BIT  = 1;

endpackage

// File: hw/branch_resolve.sv
`timescale 1ns/1ps

module branch_resolve (
  input  branch_pkg::ex_branch_t  ex_branch,
  output branch_pkg::redirect_t   redirect,
  output branch_pkg::lut_update_t lut_update
);

  import branch_pkg::*;

  logic                  cond;
  logic                  conditional;
  logic                  mispredict;
  flush_mask_t           flush;
  logic [ADDR_WIDTH-1:0] jump_address;

  // branch condition from the alu flags.
  always_comb begin
    case (ex_branch.jop)
      JMP_OP_JEQ: cond = ex_branch.flags.zero;
      JMP_OP_JNE: cond = !ex_branch.flags.zero;
      JMP_OP_JL:  cond = ex_branch.flags.less;
      JMP_OP_JLE: cond = ex_branch.flags.less | ex_branch.flags.zero;
      JMP_OP_JG:  cond = ex_branch.flags.greater;
      JMP_OP_JGE: cond = ex_branch.flags.greater | ex_branch.flags.zero;
      JMP_OP_JZ:  cond = ex_branch.flags.zero;
      JMP_OP_JNZ: cond = !ex_branch.flags.zero;
      default:    cond = 1'b0;
    endcase
  end

  assign conditional = is_cond_jump(ex_branch.jop);

  // fetch guessed wrong, everything behind execute is on the wrong path.
  assign mispredict = conditional && (cond != ex_branch.predicted_taken);

  always_comb begin
    case (ex_branch.jop)
      JMP_OP_NOP: flush = FLUSH_NONE;
      // direct jump target is known early, only the slot after execute is squashed.
      JMP_OP_J:   flush = FLUSH_EX_MEM;
      JMP_OP_JR:  flush = FLUSH_ALL;
      default: begin
        if (!conditional) begin
          flush = FLUSH_NONE;
        end else if (mispredict) begin
          flush = FLUSH_ALL;
        end else if (cond) begin
          flush = FLUSH_EX_MEM;
        end else begin
          flush = FLUSH_NONE;
        end
      end
    endcase
  end

  always_comb begin
    if (ex_branch.jop == JMP_OP_JR) begin
      jump_address = ex_branch.reg_address;
    end else if (conditional && !cond && ex_branch.predicted_taken) begin
      // predicted taken but falls through.
      jump_address = ex_branch.pc + 1'b1;
    end else begin
      jump_address = ex_branch.imm_address;
    end
  end

  assign redirect = '{
    flush:        flush,
    jump_address: jump_address
  };

  // learning record for the table and the counters.
  assign lut_update = '{
    resolved:   conditional,
    mispredict: mispredict,
    taken:      cond,
    key:        ex_branch.pc,
    target:     ex_branch.imm_address
  };

endmodule

// File: hw/branch_lut.sv
`timescale 1ns/1ps

module branch_lut #(
  parameter int LUT_INDEX_BITS = 4
) (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              enable,
  input  logic                              clear,
  input  branch_pkg::lut_update_t           lut_update,
  input  logic [branch_pkg::ADDR_WIDTH-1:0] fetch_pc,
  output branch_pkg::predict_t              predict
);

  import branch_pkg::*;

  localparam int DEPTH    = 1 << LUT_INDEX_BITS;
  localparam int TAG_BITS = ADDR_WIDTH - LUT_INDEX_BITS;

  logic [DEPTH-1:0]      valid_q;
  logic [TAG_BITS-1:0]   tag_q    [DEPTH];
  logic [ADDR_WIDTH-1:0] target_q [DEPTH];

  logic [LUT_INDEX_BITS-1:0] rd_index;
  logic [TAG_BITS-1:0]       rd_tag;
  logic [LUT_INDEX_BITS-1:0] wr_index;
  logic [TAG_BITS-1:0]       wr_tag;
  logic                      wr_tag_hit;
  logic                      learn;
  logic                      forget;

  // fetch side lookup.
  assign rd_index = fetch_pc[LUT_INDEX_BITS-1:0];
  assign rd_tag   = fetch_pc[ADDR_WIDTH-1:LUT_INDEX_BITS];

  assign predict.taken  = enable && valid_q[rd_index] && (tag_q[rd_index] == rd_tag);
  assign predict.target = target_q[rd_index];

  // update side, only mispredicts change the table.
  assign wr_index   = lut_update.key[LUT_INDEX_BITS-1:0];
  assign wr_tag     = lut_update.key[ADDR_WIDTH-1:LUT_INDEX_BITS];
  assign wr_tag_hit = tag_q[wr_index] == wr_tag;

  assign learn  = !clear && lut_update.mispredict && lut_update.taken;
  assign forget = !clear && lut_update.mispredict && !lut_update.taken && wr_tag_hit;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= '0;
    end else if (clear) begin
      valid_q <= '0;
    end else if (learn) begin
      valid_q[wr_index] <= 1'b1;
    end else if (forget) begin
      valid_q[wr_index] <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (learn) begin
      tag_q[wr_index]    <= wr_tag;
      target_q[wr_index] <= lut_update.target;
    end
  end

endmodule

// File: hw/branch_csr.sv
`timescale 1ns/1ps

module branch_csr #(
  parameter int COUNT_WIDTH = 16
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  apb_pkg::apb_req_t       apb_req,
  output apb_pkg::apb_rsp_t       apb_rsp,
  input  branch_pkg::lut_update_t lut_update,
  output logic                    enable,
  output logic                    clear
);

  import apb_pkg::*;

  logic                   access;
  logic                   mapped;
  logic                   wr_ctrl;
  logic                   wr_resolved;
  logic                   wr_mispredict;
  logic [31:0]            rdata;
  logic                   enable_q;
  logic                   clear_q;
  logic [COUNT_WIDTH-1:0] resolved_q;
  logic [COUNT_WIDTH-1:0] mispredict_q;

  // no wait states, access phase always completes.
  assign access = apb_req.psel && apb_req.penable;

  always_comb begin
    case (apb_req.paddr)
      REG_CTRL, REG_RESOLVED, REG_MISPREDICT: mapped = 1'b1;
      default: mapped = 1'b0;
    endcase
  end

  assign wr_ctrl       = access && apb_req.pwrite && (apb_req.paddr == REG_CTRL);
  assign wr_resolved   = access && apb_req.pwrite && (apb_req.paddr == REG_RESOLVED);
  assign wr_mispredict = access && apb_req.pwrite && (apb_req.paddr == REG_MISPREDICT);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      enable_q <= 1'b1;
      clear_q  <= 1'b0;
    end else begin
      clear_q <= wr_ctrl && apb_req.pwdata[CTRL_CLEAR_BIT];
      if (wr_ctrl) begin
        enable_q <= apb_req.pwdata[CTRL_ENABLE_BIT];
      end
    end
  end

  // saturating counters, a software write zeroes them and wins over counting.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      resolved_q   <= '0;
      mispredict_q <= '0;
    end else begin
      if (wr_resolved) begin
        resolved_q <= '0;
      end else if (lut_update.resolved && (resolved_q != '1)) begin
        resolved_q <= resolved_q + 1'b1;
      end
      if (wr_mispredict) begin
        mispredict_q <= '0;
      end else if (lut_update.resolved && lut_update.mispredict && (mispredict_q != '1)) begin
        mispredict_q <= mispredict_q + 1'b1;
      end
    end
  end

  always_comb begin
    case (apb_req.paddr)
      REG_CTRL:       rdata = 32'(enable_q);
      REG_RESOLVED:   rdata = 32'(resolved_q);
      REG_MISPREDICT: rdata = 32'(mispredict_q);
      default:        rdata = '0;
    endcase
  end

  assign apb_rsp.pready  = access;
  assign apb_rsp.prdata  = (access && !apb_req.pwrite) ? rdata : '0;
  assign apb_rsp.pslverr = access && !mapped;

  assign enable = enable_q;
  assign clear  = clear_q;

endmodule

// File: hw/branch_predict_top.sv
`timescale 1ns/1ps

module branch_predict_top #(
  parameter int LUT_INDEX_BITS = 4,
  parameter int COUNT_WIDTH    = 16
) (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic [branch_pkg::ADDR_WIDTH-1:0] fetch_pc,
  output branch_pkg::predict_t              predict,
  input  branch_pkg::ex_branch_t            ex_branch,
  output branch_pkg::redirect_t             redirect,
  input  apb_pkg::apb_req_t                 apb_req,
  output apb_pkg::apb_rsp_t                 apb_rsp
);

  import branch_pkg::*;

  lut_update_t lut_update;
  logic        enable;
  logic        clear;

  branch_resolve u_branch_resolve (
    .ex_branch  (ex_branch),
    .redirect   (redirect),
    .lut_update (lut_update)
  );

  // prediction table for the fetch stage.
  branch_lut #(
    .LUT_INDEX_BITS (LUT_INDEX_BITS)
  ) u_branch_lut (
    .clk        (clk),
    .rst_n      (rst_n),
    .enable     (enable),
    .clear      (clear),
    .lut_update (lut_update),
    .fetch_pc   (fetch_pc),
    .predict    (predict)
  );

  branch_csr #(
    .COUNT_WIDTH (COUNT_WIDTH)
  ) u_branch_csr (
    .clk        (clk),
    .rst_n      (rst_n),
    .apb_req    (apb_req),
    .apb_rsp    (apb_rsp),
    .lut_update (lut_update),
    .enable     (enable),
    .clear      (clear)
  );

endmodule

// File: verif/branch_tb.sv
`timescale 1ns/1ps

module branch_tb;

  import branch_pkg::*;
  import apb_pkg::*;

  localparam int CLK_PERIOD  = 40;
  localparam int DRIVE_DELAY = 2;
  localparam int INDEX_BITS  = 4;
  localparam int COUNT_WIDTH = 16;
  localparam int DEPTH       = 1 << INDEX_BITS;
  localparam int NUM_RANDOM  = 1000;
  // cycle budget of each test.
  localparam int RESET_LEN   = 50;
  localparam int RESOLVE_LEN = NUM_RANDOM + 10;
  localparam int COUNTER_LEN = 30;
  localparam int LEARN_LEN   = 20;
  localparam int CONTROL_LEN = 60;
  localparam int ERROR_LEN   = 30;
  localparam int MAX_CYCLES  =
    2 * (RESET_LEN + RESOLVE_LEN + COUNTER_LEN + LEARN_LEN + CONTROL_LEN + ERROR_LEN);

  localparam logic [ADDR_WIDTH-1:0] LEARN_PC     = 16'h0123;
  localparam logic [ADDR_WIDTH-1:0] ALIAS_PC     = 16'h1013;
  localparam logic [ADDR_WIDTH-1:0] LEARN_TARGET = 16'hbeef;
  localparam ex_branch_t            IDLE_BRANCH  = '0;

  logic                  clk;
  logic                  rst_n;
  logic [ADDR_WIDTH-1:0] fetch_pc;
  predict_t              predict;
  ex_branch_t            ex_branch;
  redirect_t             redirect;
  apb_req_t              apb_req;
  apb_rsp_t              apb_rsp;

  // reference model of the table, the control bit and the counters.
  logic                   m_valid  [DEPTH];
  logic [ADDR_WIDTH-1:0]  m_key    [DEPTH];
  logic [ADDR_WIDTH-1:0]  m_target [DEPTH];
  logic                   m_enable;
  logic [COUNT_WIDTH-1:0] m_resolved;
  logic [COUNT_WIDTH-1:0] m_mispredict;

  int          pass_count  = 0;
  int          fail_count  = 0;
  int          cycle_count = 0;
  int          mark;
  int unsigned seed;
  ex_branch_t  b;
  predict_t    exp_pred;
  logic [31:0] rdata;
  logic        err;

  // several pcs share an index so that tags alias.
  logic [ADDR_WIDTH-1:0] pc_pool [8] = '{16'h0013, 16'h1013, 16'h0123, 16'h0027,
                                         16'h0a27, 16'h0045, 16'h005c, 16'h0f5c};

  branch_predict_top #(
    .LUT_INDEX_BITS (INDEX_BITS),
    .COUNT_WIDTH    (COUNT_WIDTH)
  ) u_branch_predict_top (
    .clk       (clk),
    .rst_n     (rst_n),
    .fetch_pc  (fetch_pc),
    .predict   (predict),
    .ex_branch (ex_branch),
    .redirect  (redirect),
    .apb_req   (apb_req),
    .apb_rsp   (apb_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("timeout: the run hung after %0d cycles", cycle_count);
      $display("Regression failed");
      $finish;
    end
  end

  task automatic check_redirect(input redirect_t exp, input redirect_t act);
    if (act !== exp) begin
      $display("ERROR t=%0t redirect exp=%h act=%h", $time, exp, act);
      fail_count = fail_count + 1;
    end else begin
      pass_count = pass_count + 1;
    end
  endtask

  // the target only matters on a hit.
  task automatic check_predict(input predict_t exp, input predict_t act);
    if (act.taken !== exp.taken || (exp.taken && act.target !== exp.target)) begin
      $display("ERROR t=%0t predict exp=%h act=%h", $time, exp, act);
      fail_count = fail_count + 1;
    end else begin
      pass_count = pass_count + 1;
    end
  endtask

  task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("ERROR t=%0t %s exp=%h act=%h", $time, name, exp, act);
      fail_count = fail_count + 1;
    end else begin
      pass_count = pass_count + 1;
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("ERROR t=%0t %s exp=%b act=%b", $time, name, exp, act);
      fail_count = fail_count + 1;
    end else begin
      pass_count = pass_count + 1;
    end
  endtask

  function automatic logic model_conditional(jump_op_e jop);
    case (jop)
      JMP_OP_JEQ, JMP_OP_JNE, JMP_OP_JL, JMP_OP_JLE,
      JMP_OP_JG, JMP_OP_JGE, JMP_OP_JZ, JMP_OP_JNZ: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic model_condition(ex_branch_t br);
    case (br.jop)
      JMP_OP_JEQ, JMP_OP_JZ:  return br.flags.zero;
      JMP_OP_JNE, JMP_OP_JNZ: return !br.flags.zero;
      JMP_OP_JL:  return br.flags.less;
      JMP_OP_JLE: return br.flags.less || br.flags.zero;
      JMP_OP_JG:  return br.flags.greater;
      JMP_OP_JGE: return br.flags.greater || br.flags.zero;
      default:    return 1'b0;
    endcase
  endfunction

  function automatic redirect_t expected_redirect(ex_branch_t br);
    redirect_t r;
    logic      cond_op;
    logic      taken;
    cond_op = model_conditional(br.jop);
    taken   = model_condition(br);
    r.flush = '0;
    if (br.jop == JMP_OP_JR || (cond_op && taken != br.predicted_taken)) begin
      r.flush = '1;
    end else if (br.jop == JMP_OP_J || (cond_op && taken)) begin
      r.flush.ex_mem = 1'b1;
    end
    if (br.jop == JMP_OP_JR) begin
      r.jump_address = br.reg_address;
    end else if (cond_op && !taken && br.predicted_taken) begin
      r.jump_address = br.pc + 16'd1;
    end else begin
      r.jump_address = br.imm_address;
    end
    return r;
  endfunction

  function automatic predict_t expected_predict(logic [ADDR_WIDTH-1:0] pc);
    predict_t p;
    int       idx;
    idx      = pc[INDEX_BITS-1:0];
    p.taken  = m_enable && m_valid[idx] && (m_key[idx] == pc);
    p.target = m_target[idx];
    return p;
  endfunction

  task automatic model_clear();
    for (int i = 0; i < DEPTH; i++) begin
      m_valid[i]  = 1'b0;
      m_key[i]    = '0;
      m_target[i] = '0;
    end
  endtask

  task automatic model_update(input ex_branch_t br);
    logic cond_op;
    logic taken;
    logic miss;
    int   idx;
    cond_op = model_conditional(br.jop);
    taken   = model_condition(br);
    miss    = cond_op && (taken != br.predicted_taken);
    idx     = br.pc[INDEX_BITS-1:0];
    if (cond_op && m_resolved != '1) m_resolved = m_resolved + 1'b1;
    if (miss && m_mispredict != '1) m_mispredict = m_mispredict + 1'b1;
    if (miss && taken) begin
      m_valid[idx]  = 1'b1;
      m_key[idx]    = br.pc;
      m_target[idx] = br.imm_address;
    end else if (miss && m_key[idx] == br.pc) begin
      m_valid[idx] = 1'b0;
    end
  endtask

  function automatic logic [ADDR_WIDTH-1:0] pick_pc();
    return pc_pool[$urandom_range(0, 7)];
  endfunction

  function automatic ex_branch_t random_branch();
    ex_branch_t br;
    br.jop             = jump_op_e'(4'($urandom_range(0, 10)));
    br.flags           = 3'($urandom_range(0, 7));
    br.pc              = pick_pc();
    br.reg_address     = 16'($urandom);
    br.imm_address     = 16'($urandom);
    br.predicted_taken = 1'($urandom_range(0, 1));
    return br;
  endfunction

  // one cycle with a branch in execute and a lookup from fetch.
  task automatic run_branch(input ex_branch_t br, input logic [ADDR_WIDTH-1:0] pc);
    @(posedge clk);
    #DRIVE_DELAY;
    ex_branch = br;
    fetch_pc  = pc;
    @(negedge clk);
    check_redirect(expected_redirect(br), redirect);
    check_predict(expected_predict(pc), predict);
    model_update(br);
  endtask

  task automatic apb_transfer(input logic write, input logic [7:0] addr,
                              input logic [31:0] wdata, output logic [31:0] data,
                              output logic slverr);
    @(posedge clk);
    #DRIVE_DELAY;
    // the last branch was taken in at this edge, execute is empty from here on.
    ex_branch       = IDLE_BRANCH;
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = write;
    apb_req.paddr   = addr;
    apb_req.pwdata  = wdata;
    @(posedge clk);
    #DRIVE_DELAY;
    apb_req.penable = 1'b1;
    @(negedge clk);
    check_flag("pready", 1'b1, apb_rsp.pready);
    data   = apb_rsp.prdata;
    slverr = apb_rsp.pslverr;
    @(posedge clk);
    #DRIVE_DELAY;
    apb_req = '0;
  endtask

  task automatic reg_read(input logic [7:0] addr, input logic [31:0] exp, input string name);
    logic [31:0] data;
    logic        slverr;
    apb_transfer(1'b0, addr, 32'h0, data, slverr);
    check_word(name, exp, data);
    check_flag("pslverr", 1'b0, slverr);
  endtask

  task automatic reg_write(input logic [7:0] addr, input logic [31:0] data);
    logic [31:0] unused;
    logic        slverr;
    apb_transfer(1'b1, addr, data, unused, slverr);
    check_flag("pslverr", 1'b0, slverr);
  endtask

  task automatic end_test(input string name, input int fails_at_start);
    if (fail_count == fails_at_start) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, fail_count - fails_at_start);
    end
  endtask

  initial begin
    rst_n     = 1'b0;
    fetch_pc  = '0;
    ex_branch = IDLE_BRANCH;
    apb_req   = '0;
    seed      = 32'hda22ab69;
    void'($urandom(seed));
    model_clear();
    m_enable     = 1'b1;
    m_resolved   = '0;
    m_mispredict = '0;
    repeat (10) @(posedge clk);
    #DRIVE_DELAY;
    rst_n = 1'b1;

    mark = fail_count;
    for (int i = 0; i < 16; i++) run_branch(IDLE_BRANCH, 16'($urandom));
    reg_read(REG_CTRL, 32'h1, "ctrl");
    reg_read(REG_RESOLVED, 32'h0, "resolved");
    reg_read(REG_MISPREDICT, 32'h0, "mispredict");
    end_test("reset", mark);

    mark = fail_count;
    for (int i = 0; i < NUM_RANDOM; i++) run_branch(random_branch(), pick_pc());
    end_test("resolution", mark);

    mark = fail_count;
    reg_read(REG_RESOLVED, 32'(m_resolved), "resolved");
    reg_read(REG_MISPREDICT, 32'(m_mispredict), "mispredict");
    reg_write(REG_RESOLVED, 32'h1234);
    m_resolved = '0;
    reg_write(REG_MISPREDICT, 32'h5678);
    m_mispredict = '0;
    reg_read(REG_RESOLVED, 32'h0, "resolved");
    reg_read(REG_MISPREDICT, 32'h0, "mispredict");
    end_test("counters", mark);

    mark = fail_count;
    b                 = IDLE_BRANCH;
    b.jop             = JMP_OP_JEQ;
    b.flags.zero      = 1'b1;
    b.pc              = LEARN_PC;
    b.imm_address     = LEARN_TARGET;
    run_branch(b, LEARN_PC);
    run_branch(IDLE_BRANCH, LEARN_PC);
    exp_pred.taken  = 1'b1;
    exp_pred.target = LEARN_TARGET;
    check_predict(exp_pred, predict);
    run_branch(IDLE_BRANCH, ALIAS_PC);
    check_flag("predict.taken", 1'b0, predict.taken);
    // zero is set, so JNE falls through against a taken guess.
    b.jop             = JMP_OP_JNE;
    b.predicted_taken = 1'b1;
    run_branch(b, LEARN_PC);
    run_branch(IDLE_BRANCH, LEARN_PC);
    check_flag("predict.taken", 1'b0, predict.taken);
    end_test("learning", mark);

    mark = fail_count;
    b                 = IDLE_BRANCH;
    b.jop             = JMP_OP_JG;
    b.flags.greater   = 1'b1;
    b.pc              = LEARN_PC;
    b.imm_address     = LEARN_TARGET;
    run_branch(b, LEARN_PC);
    reg_write(REG_CTRL, 32'h0);
    m_enable = 1'b0;
    for (int i = 0; i < 8; i++) begin
      run_branch(IDLE_BRANCH, pc_pool[i]);
      check_flag("predict.taken", 1'b0, predict.taken);
    end
    reg_write(REG_CTRL, 32'h1);
    m_enable = 1'b1;
    for (int i = 0; i < 8; i++) run_branch(IDLE_BRANCH, pc_pool[i]);
    run_branch(IDLE_BRANCH, LEARN_PC);
    check_flag("predict.taken", 1'b1, predict.taken);
    reg_write(REG_CTRL, 32'h3);
    model_clear();
    for (int i = 0; i < 8; i++) begin
      run_branch(IDLE_BRANCH, pc_pool[i]);
      check_flag("predict.taken", 1'b0, predict.taken);
    end
    reg_read(REG_CTRL, 32'h1, "ctrl");
    end_test("control", mark);

    mark = fail_count;
    apb_transfer(1'b1, 8'h0c, 32'h0, rdata, err);
    check_flag("pslverr", 1'b1, err);
    apb_transfer(1'b0, 8'h0c, 32'h0, rdata, err);
    check_flag("pslverr", 1'b1, err);
    reg_read(REG_CTRL, 32'(m_enable), "ctrl");
    reg_read(REG_RESOLVED, 32'(m_resolved), "resolved");
    reg_read(REG_MISPREDICT, 32'(m_mispredict), "mispredict");
    end_test("errors", mark);

    $display("checks passed %0d, failed %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// File: branch_predict_top.f
hw/branch_pkg.sv
hw/apb_pkg.sv
hw/branch_resolve.sv
hw/branch_lut.sv
hw/branch_csr.sv
hw/branch_predict_top.sv
verif/branch_tb.sv
